// ==== files.f ====
hw/rs_pkg.sv
hw/exec_alu.sv
hw/exec_mult.sv
hw/cdb_arbiter.sv
hw/rs_slot_array.sv
hw/rs_top.sv
sim/rs_asserts.sv
sim/rs_tb.sv

// ==== sim/rs_tb.sv ====
/* reservation station testbench: LCG stimulus, scoreboard by tag,
   checking assertions and watchdog */
`default_nettype none
`timescale 1ns/1ps

module rs_tb import rs_pkg::*; ();

    localparam int num_alu   = 4;
    localparam int num_mult  = 2;
    localparam int num_tags  = 1 << tag_w;
    localparam logic [tag_w-1:0] stall_tag = tag_w'(num_tags - 1);
    localparam int n_indep   = 24;
    localparam int n_dep     = 40;
    localparam int n_mul     = 3;
    localparam int n_post    = 20;
    localparam int n_total   = n_indep + n_dep + num_alu + n_mul + num_mult + n_post;
    localparam int watchdog_cycles = n_total * 20 + 100;

    logic       clock;
    logic       reset;
    logic       dispatch_valid;
    dispatch_t  dispatch;
    logic       squash;
    cdb_t       cdb;
    rs_status_t status;

    // scoreboard, indexed by tag
    logic [xlen-1:0]  exp_value   [num_tags] = '{default: '0};
    logic [tag_w-1:0] prod_a_of   [num_tags] = '{default: '0};
    logic [tag_w-1:0] prod_b_of   [num_tags] = '{default: '0};
    int               disp_count  [num_tags] = '{default: 0};
    int               bcast_count [num_tags] = '{default: 0};
    int               kill_count  [num_tags] = '{default: 0};

    logic [31:0]      rng_state;
    logic [tag_w-1:0] next_tag;
    logic             any_dispatched;
    logic             alu_blocked;

    logic [xlen-1:0]  exp_at_cdb;
    logic [tag_w-1:0] prod_a;
    logic [tag_w-1:0] prod_b;
    logic             cdb_pending;
    logic             deps_done;

    rs_top #(
        .num_alu  (num_alu),
        .num_mult (num_mult)
    ) u_dut (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .squash         (squash),
        .cdb            (cdb),
        .status         (status)
    );

    always #2 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and helpers

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n;
    endfunction

    function automatic logic [xlen-1:0] apply_op(rs_op_e op, logic [xlen-1:0] a,
                                                  logic [xlen-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    // producer not yet seen on the bus, the bus as sampled at this edge included
    function automatic logic in_flight(logic [tag_w-1:0] t);
        if (t == stall_tag) begin
            return 1'b1;
        end
        if (cdb.valid && cdb.tag == t) begin
            return 1'b0;
        end
        return disp_count[t] > bcast_count[t] + kill_count[t];
    endfunction

    function automatic logic any_pending();
        for (int t = 1; t < num_tags - 1; t++) begin
            if (in_flight(tag_w'(t))) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic operand_t make_source(logic [tag_w-1:0] dep);
        operand_t src;
        src.tag   = dep;
        src.value = next_rand();
        src.ready = (dep == no_tag) || !in_flight(dep);
        if (dep != no_tag && src.ready) begin
            src.value = exp_value[dep];
        end
        return src;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [xlen-1:0] expected,
                                   input logic [xlen-1:0] actual);
        report_failure($sformatf("[FAIL] %0t %s expected %h actual %h",
                                 $time, name, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    // one dispatch every other cycle so the full flags are current
    task automatic send(input rs_op_e op, input logic [tag_w-1:0] dep_a,
                        input logic [tag_w-1:0] dep_b);
        dispatch_t       pkt;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        @(posedge clock);
        while ((op == op_mul) ? status.mult_full : status.alu_full) begin
            @(posedge clock);
        end
        pkt.op       = op;
        pkt.dest_tag = next_tag;
        pkt.src_a    = make_source(dep_a);
        pkt.src_b    = make_source(dep_b);
        a = (dep_a == no_tag) ? pkt.src_a.value : exp_value[dep_a];
        b = (dep_b == no_tag) ? pkt.src_b.value : exp_value[dep_b];
        exp_value[next_tag]  = apply_op(op, a, b);
        prod_a_of[next_tag]  = pkt.src_a.ready ? no_tag : dep_a;
        prod_b_of[next_tag]  = pkt.src_b.ready ? no_tag : dep_b;
        disp_count[next_tag] = disp_count[next_tag] + 1;
        any_dispatched = 1'b1;
        dispatch_valid <= 1'b1;
        dispatch       <= pkt;
        @(posedge clock);
        dispatch_valid <= 1'b0;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic wait_idle();
        @(posedge clock);
        while (any_pending()) begin
            @(posedge clock);
        end
    endtask

    task automatic wait_tag(input logic [tag_w-1:0] t);
        @(posedge clock);
        while (in_flight(t)) begin
            @(posedge clock);
        end
    endtask

    task automatic run_stream(input int count, input logic chain);
        rs_op_e           op;
        logic [tag_w-1:0] dep_a;
        logic [tag_w-1:0] dep_b;
        int               span;
        for (int n = 0; n < count; n++) begin
            // out of tags, drain before reuse
            if (next_tag == stall_tag) begin
                wait_idle();
                next_tag = 1;
            end
            op    = rs_op_e'(rand_below(6));
            dep_a = no_tag;
            dep_b = no_tag;
            span  = (next_tag > 4) ? 4 : int'(next_tag) - 1;
            if (chain && span > 0) begin
                if (rand_below(4) != 0) begin
                    dep_a = next_tag - 1'b1 - tag_w'(rand_below(span));
                end
                if (rand_below(2) != 0) begin
                    dep_b = next_tag - 1'b1 - tag_w'(rand_below(span));
                end
            end
            send(op, dep_a, dep_b);
        end
    endtask

    task automatic squash_all();
        @(posedge clock);
        squash <= 1'b1;
        @(posedge clock);
        squash <= 1'b0;
        for (int t = 1; t < num_tags - 1; t++) begin
            if (disp_count[t] > bcast_count[t] + kill_count[t]) begin
                kill_count[t] = kill_count[t] + 1;
            end
        end
        next_tag = 1;
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        squash         = 1'b0;
        rng_state      = 32'h216a_04a9;
        next_tag       = 1;
        any_dispatched = 1'b0;
        alu_blocked    = 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        repeat (5) @(posedge clock);
        run_stream(n_indep, 1'b0);
        run_stream(n_dep, 1'b1);
        wait_idle();
        next_tag = 1;
        // ALU slots wait on a tag that never shows up
        for (int i = 0; i < num_alu; i++) begin
            send(rs_op_e'(rand_below(5)), stall_tag, no_tag);
        end
        alu_blocked = 1'b1;
        for (int i = 0; i < num_mul_sends(); i++) begin
            send(op_mul, no_tag, no_tag);
            wait_tag(next_tag - 1'b1);
        end
        alu_blocked = 1'b0;
        // one multiplier slot stuck and one still in its pipeline at squash
        for (int i = 0; i < num_mult; i++) begin
            send(op_mul, (i == 0) ? stall_tag : no_tag, no_tag);
        end
        squash_all();
        run_stream(n_post, 1'b1);
        wait_idle();
        $display("** PASS **");
        $finish;
    end

    function automatic int num_mul_sends();
        return n_mul;
    endfunction

    always @(posedge clock) begin
        if (!reset && cdb.valid) begin
            bcast_count[cdb.tag] <= bcast_count[cdb.tag] + 1;
        end
    end

    always @(posedge clock) begin
        if (u_dut.u_asserts.violation) begin
            report_failure("a protocol assertion bound into rs_top failed");
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        report_failure("watchdog expired before all instructions finished");
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks

    assign exp_at_cdb  = exp_value[cdb.tag];
    assign prod_a      = prod_a_of[cdb.tag];
    assign prod_b      = prod_b_of[cdb.tag];
    assign cdb_pending = disp_count[cdb.tag] > bcast_count[cdb.tag] + kill_count[cdb.tag];
    assign deps_done   = disp_count[prod_a] == bcast_count[prod_a] + kill_count[prod_a]
                         && disp_count[prod_b] == bcast_count[prod_b] + kill_count[prod_b];

    idle_cdb: assert property (@(posedge clock) disable iff (reset)
        !any_dispatched |-> !cdb.valid)
        else report_mismatch("cdb.valid", 0, $sampled(cdb.valid));
    idle_alu_full: assert property (@(posedge clock) disable iff (reset)
        !any_dispatched |-> !status.alu_full)
        else report_mismatch("status.alu_full", 0, $sampled(status.alu_full));
    idle_mult_full: assert property (@(posedge clock) disable iff (reset)
        !any_dispatched |-> !status.mult_full)
        else report_mismatch("status.mult_full", 0, $sampled(status.mult_full));

    cdb_value: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> cdb.value == exp_at_cdb)
        else report_mismatch("cdb.value", $sampled(exp_at_cdb), $sampled(cdb.value));
    cdb_once: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> cdb_pending)
        else report_failure($sformatf("tag %0d was broadcast but is not in flight",
                                      $sampled(cdb.tag)));
    cdb_order: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> deps_done)
        else report_failure($sformatf("tag %0d was broadcast before its producer",
                                      $sampled(cdb.tag)));

    // blocked ALU slots
    stall_alu_full: assert property (@(posedge clock) disable iff (reset)
        alu_blocked |-> status.alu_full)
        else report_mismatch("status.alu_full", 1, $sampled(status.alu_full));
    stall_mult_free: assert property (@(posedge clock) disable iff (reset)
        alu_blocked |-> !status.mult_full)
        else report_mismatch("status.mult_full", 0, $sampled(status.mult_full));

    squash_alu_free: assert property (@(posedge clock) disable iff (reset)
        squash |=> !status.alu_full)
        else report_mismatch("status.alu_full", 0, $sampled(status.alu_full));
    squash_mult_free: assert property (@(posedge clock) disable iff (reset)
        squash |=> !status.mult_full)
        else report_mismatch("status.mult_full", 0, $sampled(status.mult_full));

endmodule

`default_nettype wire

// ==== sim/rs_asserts.sv ====
/* protocol assertions for the reservation station, bound into rs_top */
`default_nettype none
`timescale 1ns/1ps

module rs_asserts import rs_pkg::*; (
    input wire logic       clock,
    input wire logic       reset,
    input wire logic       squash,
    input wire logic       dispatch_valid,
    input wire dispatch_t  dispatch,
    input wire cdb_t       cdb,
    input wire rs_status_t status
);

    // raised by any failing rule, watched from the testbench
    logic violation = 1'b0;
    logic cat_full;

    assign cat_full = (dispatch.op == op_mul) ? status.mult_full : status.alu_full;

    cdb_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> cdb.tag != no_tag)
        else begin
            $error("cdb valid while carrying tag 0");
            violation = 1'b1;
        end

    no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
        dispatch_valid |-> !cat_full)
        else begin
            $error("dispatch strobe while its category is full");
            violation = 1'b1;
        end

    cdb_quiet_after_squash: assert property (@(posedge clock) disable iff (reset)
        squash |=> !cdb.valid)
        else begin
            $error("cdb valid in the cycle after squash");
            violation = 1'b1;
        end

endmodule

bind rs_top rs_asserts u_asserts (.*);

`default_nettype wire

// ==== hw/rs_top.sv ====
/* reservation station top level: slot array, ALU and multiplier units,
   result bus arbiter */
`default_nettype none
`timescale 1ns/1ps

module rs_top import rs_pkg::*; #(
    parameter int num_alu  = 4,
    parameter int num_mult = 2
) (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       dispatch_valid,
    input  wire dispatch_t  dispatch,
    input  wire logic       squash,
    output cdb_t            cdb,
    output rs_status_t      status
);

    localparam int num_slots = num_alu + num_mult;

    logic   [num_slots-1:0]             issue;
    rs_op_e [num_slots-1:0]             slot_op;
    logic   [num_slots-1:0][xlen-1:0]   src_a;
    logic   [num_slots-1:0][xlen-1:0]   src_b;
    logic   [num_slots-1:0][tag_w-1:0]  dest_tag;
    logic   [num_slots-1:0]             grant;
    logic   [num_slots-1:0]             done;
    logic   [num_slots-1:0][xlen-1:0]   result;

    rs_slot_array #(
        .num_alu  (num_alu),
        .num_mult (num_mult)
    ) u_slots (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .grant          (grant),
        .issue          (issue),
        .slot_op        (slot_op),
        .src_a          (src_a),
        .src_b          (src_b),
        .dest_tag       (dest_tag),
        .status         (status)
    );

    ////////////////////////////////////////////////////////////////////////////
    // one unit per slot, ALU slots first

    for (genvar i = 0; i < num_alu; i++) begin : g_alu
        exec_alu u_alu (
            .clock  (clock),
            .reset  (reset),
            .squash (squash),
            .issue  (issue[i]),
            .op     (slot_op[i]),
            .src_a  (src_a[i]),
            .src_b  (src_b[i]),
            .grant  (grant[i]),
            .done   (done[i]),
            .result (result[i])
        );
    end

    for (genvar j = 0; j < num_mult; j++) begin : g_mult
        exec_mult u_mult (
            .clock  (clock),
            .reset  (reset),
            .squash (squash),
            .issue  (issue[num_alu+j]),
            .src_a  (src_a[num_alu+j]),
            .src_b  (src_b[num_alu+j]),
            .grant  (grant[num_alu+j]),
            .done   (done[num_alu+j]),
            .result (result[num_alu+j])
        );
    end

    cdb_arbiter #(
        .num_slots (num_slots)
    ) u_arb (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .done     (done),
        .result   (result),
        .dest_tag (dest_tag),
        .grant    (grant),
        .cdb      (cdb)
    );

endmodule

`default_nettype wire

// ==== hw/rs_slot_array.sv ====
/* slot storage with allocation by category, operand wakeup from the
   broadcast bus, issue strobes, freeing on grant and full flags */
`default_nettype none
`timescale 1ns/1ps

module rs_slot_array import rs_pkg::*; #(
    parameter int num_alu  = 4,
    parameter int num_mult = 2
) (
    input  wire logic                                       clock,
    input  wire logic                                       reset,
    input  wire logic                                       squash,
    input  wire logic                                       dispatch_valid,
    input  wire dispatch_t                                  dispatch,
    input  wire cdb_t                                       cdb,
    input  wire logic [num_alu+num_mult-1:0]                grant,
    output logic      [num_alu+num_mult-1:0]                issue,
    output rs_op_e    [num_alu+num_mult-1:0]                slot_op,
    output logic      [num_alu+num_mult-1:0][xlen-1:0]      src_a,
    output logic      [num_alu+num_mult-1:0][xlen-1:0]      src_b,
    output logic      [num_alu+num_mult-1:0][tag_w-1:0]     dest_tag,
    output rs_status_t                                      status
);

    localparam int num_slots = num_alu + num_mult;

    slot_t                  slots [num_slots];
    logic [num_slots-1:0]   busy;
    logic [num_slots-1:0]   issued;
    logic [num_slots-1:0]   alloc;

    // pick up a value broadcast this cycle for a waiting source
    function automatic operand_t capture(operand_t src, cdb_t bus);
        operand_t res;
        res = src;
        if (!src.ready && bus.valid && bus.tag == src.tag) begin
            res.value = bus.value;
            res.ready = 1'b1;
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // allocation, lowest free slot of the opcode's category

    always_comb begin
        int   lo;
        int   hi;
        logic found;
        lo    = (dispatch.op == op_mul) ? num_alu : 0;
        hi    = (dispatch.op == op_mul) ? num_slots : num_alu;
        found = 1'b0;
        alloc = '0;
        for (int i = 0; i < num_slots; i++) begin
            if (dispatch_valid && !found && i >= lo && i < hi && !busy[i]) begin
                alloc[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

    // full flags straight off the registered busy bits
    assign status.alu_full  = &busy[num_alu-1:0];
    assign status.mult_full = &busy[num_slots-1:num_alu];

    ////////////////////////////////////////////////////////////////////////////
    // control state

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy   <= '0;
            issued <= '0;
        end else begin
            for (int i = 0; i < num_slots; i++) begin
                if (grant[i]) begin
                    busy[i]   <= 1'b0;
                    issued[i] <= 1'b0;
                end else if (alloc[i]) begin
                    busy[i]   <= 1'b1;
                    issued[i] <= 1'b0;
                end else if (issue[i]) begin
                    issued[i] <= 1'b1;
                end
            end
        end
    end

    // payload, only meaningful while busy
    always_ff @(posedge clock) begin
        for (int i = 0; i < num_slots; i++) begin
            if (alloc[i]) begin
                slots[i].op       <= dispatch.op;
                slots[i].dest_tag <= dispatch.dest_tag;
                slots[i].src_a    <= capture(dispatch.src_a, cdb);
                slots[i].src_b    <= capture(dispatch.src_b, cdb);
            end else begin
                slots[i].src_a <= capture(slots[i].src_a, cdb);
                slots[i].src_b <= capture(slots[i].src_b, cdb);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // per-slot outputs to the units and the arbiter

    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            issue[i]    = busy[i] && !issued[i]
                          && slots[i].src_a.ready && slots[i].src_b.ready;
            slot_op[i]  = slots[i].op;
            src_a[i]    = slots[i].src_a.value;
            src_b[i]    = slots[i].src_b.value;
            dest_tag[i] = slots[i].dest_tag;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cdb_arbiter.sv ====
/* round-robin arbiter that puts one finished unit per cycle on the
   result broadcast bus */
`default_nettype none
`timescale 1ns/1ps

module cdb_arbiter import rs_pkg::*; #(
    parameter int num_slots = 6
) (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic                                  squash,
    input  wire logic [num_slots-1:0]                  done,
    input  wire logic [num_slots-1:0][xlen-1:0]        result,
    input  wire logic [num_slots-1:0][tag_w-1:0]       dest_tag,
    output logic      [num_slots-1:0]                  grant,
    output cdb_t                                       cdb
);

    localparam int ptr_w = (num_slots > 1) ? $clog2(num_slots) : 1;

    logic [ptr_w-1:0] last_q;
    logic [ptr_w-1:0] win;
    logic             any_done;

    assign any_done = |done;

    // search starts one past the last winner
    always_comb begin
        int   idx;
        logic found;
        win   = last_q;
        found = 1'b0;
        for (int k = 1; k <= num_slots; k++) begin
            idx = (int'(last_q) + k) % num_slots;
            if (!found && done[idx]) begin
                win   = ptr_w'(idx);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (any_done && !squash) begin
            grant[win] = 1'b1;
        end
    end

    // nothing squashed goes out
    assign cdb.valid = any_done && !squash;
    assign cdb.tag   = dest_tag[win];
    assign cdb.value = result[win];

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            last_q <= ptr_w'(num_slots - 1);
        end else if (any_done) begin
            last_q <= win;
        end
    end

endmodule

`default_nettype wire

// ==== hw/exec_mult.sv ====
/* two-stage multiplier unit, low word of the product held until granted */
`default_nettype none
`timescale 1ns/1ps

module exec_mult import rs_pkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            squash,
    input  wire logic            issue,
    input  wire logic [xlen-1:0] src_a,
    input  wire logic [xlen-1:0] src_b,
    input  wire logic            grant,
    output logic                 done,
    output logic      [xlen-1:0] result
);

    // stage one, operands
    logic            s1_valid;
    logic [xlen-1:0] s1_a;
    logic [xlen-1:0] s1_b;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= issue;
            if (s1_valid) begin
                done <= 1'b1;
            end else if (grant) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            s1_a <= src_a;
            s1_b <= src_b;
        end
    end

    // stage two, product
    always_ff @(posedge clock) begin
        if (s1_valid) begin
            result <= s1_a * s1_b;
        end
    end

endmodule

`default_nettype wire

// ==== hw/exec_alu.sv ====
/* single-cycle integer ALU unit, result held until granted */
`default_nettype none
`timescale 1ns/1ps

module exec_alu import rs_pkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            squash,
    input  wire logic            issue,
    input  wire rs_op_e          op,
    input  wire logic [xlen-1:0] src_a,
    input  wire logic [xlen-1:0] src_b,
    input  wire logic            grant,
    output logic                 done,
    output logic      [xlen-1:0] result
);

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            done <= 1'b0;
        end else if (issue) begin
            done <= 1'b1;
        end else if (grant) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            case (op)
                op_add:  result <= src_a + src_b;
                op_sub:  result <= src_a - src_b;
                op_and:  result <= src_a & src_b;
                op_or:   result <= src_a | src_b;
                op_xor:  result <= src_a ^ src_b;
                default: result <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/rs_pkg.sv ====
/* shared widths, opcode enum and packed structs for dispatch, operands,
   slots, the result broadcast bus and the full status */
`default_nettype none

package rs_pkg;

    localparam int xlen  = 32;
    localparam int tag_w = 5;

    // tag 0 means no producer, never a destination
    localparam logic [tag_w-1:0] no_tag = '0;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_mul
    } rs_op_e;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
        logic             ready;
    } operand_t;

    typedef struct packed {
        rs_op_e           op;
        logic [tag_w-1:0] dest_tag;
        operand_t         src_a;
        operand_t         src_b;
    } dispatch_t;

    // same layout as the dispatch packet, kept apart on purpose
    typedef struct packed {
        rs_op_e           op;
        logic [tag_w-1:0] dest_tag;
        operand_t         src_a;
        operand_t         src_b;
    } slot_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
    } cdb_t;

    typedef struct packed {
        logic alu_full;
        logic mult_full;
    } rs_status_t;

endpackage

`default_nettype wire
